//--- sdram_pkg.sv
package sdram_pkg;

    // device geometry, one word per column
    localparam int ROW_BITS = 12;
    localparam int COL_BITS = 8;
    localparam int BANK_BITS = 2;
    localparam int ADDR_BITS = BANK_BITS + COL_BITS + ROW_BITS;
    localparam int CH_BITS = 4;  // room for up to 16 host channels

    // timing in clocks
    localparam int T_RP = 2;
    localparam int T_MRD = 2;
    localparam int T_RCD = 2;
    localparam int CAS_LATENCY = 2;
    localparam int READ_PERIOD = 7;  // tras + trp
    localparam int WRITE_PERIOD = 9;  // tras + trp + twr

    // ras, cas, we
    typedef enum logic [2:0] {
        NOOP              = 3'b111,
        ACTIVATE          = 3'b011,
        MODE_REGISTER_SET = 3'b000,
        AUTO_REFRESH      = 3'b001,
        READ              = 3'b101,
        WRITE             = 3'b100,
        PRECHARGE         = 3'b010
    } sdram_cmd_e;

    typedef logic [CH_BITS-1:0] ch_idx_t;

    typedef struct packed {
        logic [BANK_BITS-1:0] bank;
        logic [COL_BITS-1:0]  col;
        logic [ROW_BITS-1:0]  row;
    } host_addr_t;

    typedef struct packed {
        logic        req;  // toggles once per request
        logic        we;
        host_addr_t  addr;
        logic [15:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } host_rsp_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        host_addr_t  addr;
        logic [15:0] wdata;
    } pending_req_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        ch_idx_t     ch;
        logic [15:0] rdata;
    } completion_t;

    // address bus as seen by MODE_REGISTER_SET
    typedef struct packed {
        logic [ROW_BITS-11:0] rsvd;
        logic                 write_burst;  // 1 for single write
        logic [1:0]           op_mode;
        logic [2:0]           cas_latency;
        logic                 addr_type;  // 0 for sequential
        logic [2:0]           burst_len;
    } mode_word_t;

    // address bus for ACTIVATE, READ, WRITE and PRECHARGE
    typedef struct packed {
        logic [ROW_BITS-12:0] upper;
        logic                 ap;  // a10, auto-precharge or all banks
        logic [ROW_BITS-3:0]  col_row;
    } access_word_t;

    typedef union packed {
        mode_word_t   mode;
        access_word_t access;
    } sdram_addr_u;

endpackage

//--- channel_port.sv
`timescale 1ns/1ps

module channel_port (
    input  logic                    sdram_clk,
    input  logic                    reset,
    input  sdram_pkg::ch_idx_t      idx,
    input  sdram_pkg::host_req_t    req_in,
    input  sdram_pkg::completion_t  cmpl,
    output sdram_pkg::pending_req_t pend,
    output sdram_pkg::host_rsp_t    rsp
);

    logic        ack_q;
    logic [15:0] rdata_q;
    logic        hit;

    assign hit = cmpl.valid && (cmpl.ch == idx);

    always_ff @(posedge sdram_clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else if (hit) begin
            ack_q <= req_in.req;  // closes the toggle
        end
    end

    always_ff @(posedge sdram_clk) begin
        if (hit && !cmpl.we) begin
            rdata_q <= cmpl.rdata;
        end
    end

    assign pend.valid = (req_in.req != ack_q);
    assign pend.we = req_in.we;
    assign pend.addr = req_in.addr;
    assign pend.wdata = req_in.wdata;

    assign rsp.ack = ack_q;
    assign rsp.rdata = rdata_q;

    // host holds the whole request until the ack catches up
    assert property (@(posedge sdram_clk) disable iff (reset)
        (pend.valid && !hit) |=> ($stable(req_in.req) && $stable(req_in.we)
            && $stable(req_in.addr) && $stable(req_in.wdata)));

endmodule

//--- request_arbiter.sv
`timescale 1ns/1ps

module request_arbiter #(
    parameter int num_ch = 2
) (
    input  sdram_pkg::pending_req_t pend [num_ch],
    output sdram_pkg::pending_req_t sel_req,
    output sdram_pkg::ch_idx_t      grant_idx
);

    logic any_valid;

    // walk downwards so the lowest pending index wins
    always_comb begin
        sel_req = '0;
        grant_idx = '0;
        for (int i = num_ch - 1; i >= 0; i--) begin
            if (pend[i].valid) begin
                sel_req = pend[i];
                grant_idx = sdram_pkg::ch_idx_t'(i);
            end
        end
    end

    always_comb begin
        any_valid = 1'b0;
        foreach (pend[i]) begin
            any_valid = any_valid | pend[i].valid;
        end
    end

    always_comb begin
        assert final (sel_req.valid == any_valid);
    end

endmodule

//--- refresh_timer.sv
`timescale 1ns/1ps

module refresh_timer #(
    parameter int refresh_interval = 2080
) (
    input  logic sdram_clk,
    input  logic reset,
    input  logic enable,
    input  logic refresh_hint,
    input  logic refresh_done,
    output logic refresh_due
);

    localparam int CNT_BITS = $clog2(refresh_interval + 1);

    logic [CNT_BITS-1:0] count;
    logic                due_q;
    logic                hit;

    assign hit = (count == CNT_BITS'(refresh_interval))
        || (refresh_hint && (count >= CNT_BITS'(refresh_interval / 2)));
    assign refresh_due = due_q || hit;

    always_ff @(posedge sdram_clk) begin
        if (reset || !enable) begin
            count <= '0;
            due_q <= 1'b0;
        end else if (refresh_done) begin
            count <= '0;
            due_q <= 1'b0;
        end else begin
            if (count != CNT_BITS'(refresh_interval)) begin
                count <= count + 1'b1;  // saturates at the interval
            end
            due_q <= refresh_due;
        end
    end

    // the sequencer only refreshes after seeing the flag
    assert property (@(posedge sdram_clk) disable iff (reset)
        refresh_done |-> due_q);

endmodule

//--- sdram_sequencer.sv
`timescale 1ns/1ps

module sdram_sequencer #(
    parameter int init_pause = 26_667
) (
    input  logic                            sdram_clk,
    input  logic                            reset,
    input  logic                            init,
    input  sdram_pkg::pending_req_t         sel_req,
    input  sdram_pkg::ch_idx_t              grant_idx,
    input  logic                            refresh_due,
    output logic                            take,
    output logic                            refresh_done,
    output logic                            cfg_done,
    output sdram_pkg::completion_t          cmpl,
    output logic                            sdram_cs,
    output logic                            sdram_ras,
    output logic                            sdram_cas,
    output logic                            sdram_we,
    output logic [sdram_pkg::BANK_BITS-1:0] sdram_ba,
    output sdram_pkg::sdram_addr_u          sdram_addr,
    output logic [1:0]                      sdram_dqm,
    inout  wire  [15:0]                     sdram_dq
);

    localparam int STEP_BITS = $clog2(init_pause + 32);
    localparam int LOW_BITS = sdram_pkg::ROW_BITS - 2;

    // configuration steps
    localparam int CFG_PRECHARGE = 0;
    localparam int CFG_SET_MODE = CFG_PRECHARGE + sdram_pkg::T_RP;
    localparam int CFG_REFRESH_1 = CFG_SET_MODE + sdram_pkg::T_MRD;
    localparam int CFG_REFRESH_2 = CFG_REFRESH_1 + sdram_pkg::READ_PERIOD + 1;
    localparam int CFG_END = CFG_REFRESH_2 + sdram_pkg::READ_PERIOD;

    // access and refresh steps, the ACTIVATE or AUTO_REFRESH cycle is step 1
    localparam int ACT_START = 1;
    localparam int ACT_CMD = sdram_pkg::T_RCD;
    localparam int ACT_READY = sdram_pkg::T_RCD + sdram_pkg::CAS_LATENCY + 1;

    typedef enum logic [2:0] {
        POWERUP,
        CONFIGURE,
        IDLE,
        ACTIVE,
        REFRESH
    } state_e;

    state_e                          state;
    logic [STEP_BITS-1:0]            step;
    sdram_pkg::sdram_cmd_e           cmd_q;
    logic                            dq_oe;
    logic                            we_q;
    sdram_pkg::ch_idx_t              ch_q;
    logic [sdram_pkg::BANK_BITS-1:0] bank_q;
    logic [sdram_pkg::COL_BITS-1:0]  col_q;
    logic [15:0]                     wdata_q;

    assign {sdram_ras, sdram_cas, sdram_we} = cmd_q;
    assign sdram_cs = (cmd_q == sdram_pkg::NOOP);  // active low, deselect on noop
    assign sdram_dq = dq_oe ? wdata_q : 'z;

    always_ff @(posedge sdram_clk) begin
        if (reset) begin
            state <= POWERUP;
            step <= '0;
            cmd_q <= sdram_pkg::NOOP;
            sdram_dqm <= 2'b11;
            dq_oe <= 1'b0;
            we_q <= 1'b0;
            take <= 1'b0;
            refresh_done <= 1'b0;
            cfg_done <= 1'b0;
            cmpl.valid <= 1'b0;
        end else begin
            cmd_q <= sdram_pkg::NOOP;
            dq_oe <= 1'b0;
            take <= 1'b0;
            refresh_done <= 1'b0;
            cmpl.valid <= 1'b0;

            case (state)
                POWERUP: begin
                    if (step != STEP_BITS'(init_pause)) begin
                        step <= step + 1'b1;
                    end else if (init) begin
                        step <= '0;
                        state <= CONFIGURE;
                    end
                end
                CONFIGURE: begin
                    step <= step + 1'b1;
                    case (step)
                        STEP_BITS'(CFG_PRECHARGE): begin
                            sdram_addr.access <= '{upper: '0, ap: 1'b1, col_row: '0};
                            cmd_q <= sdram_pkg::PRECHARGE;  // all banks
                        end
                        STEP_BITS'(CFG_SET_MODE): begin
                            sdram_ba <= '0;
                            sdram_addr.mode <= '{
                                rsvd: '0,
                                write_burst: 1'b1,
                                op_mode: 2'b00,
                                cas_latency: 3'(sdram_pkg::CAS_LATENCY),
                                addr_type: 1'b0,
                                burst_len: 3'd0
                            };
                            cmd_q <= sdram_pkg::MODE_REGISTER_SET;
                        end
                        STEP_BITS'(CFG_REFRESH_1), STEP_BITS'(CFG_REFRESH_2): begin
                            cmd_q <= sdram_pkg::AUTO_REFRESH;
                        end
                        STEP_BITS'(CFG_END): begin
                            step <= '0;
                            cfg_done <= 1'b1;
                            state <= IDLE;
                        end
                        default: begin
                        end
                    endcase
                end
                IDLE: begin
                    step <= STEP_BITS'(ACT_START);
                    if (refresh_due) begin  // refresh wins over hosts
                        cmd_q <= sdram_pkg::AUTO_REFRESH;
                        refresh_done <= 1'b1;
                        state <= REFRESH;
                    end else if (sel_req.valid) begin
                        sdram_ba <= sel_req.addr.bank;
                        sdram_addr.access <= sdram_pkg::access_word_t'(sel_req.addr.row);
                        bank_q <= sel_req.addr.bank;
                        col_q <= sel_req.addr.col;
                        wdata_q <= sel_req.wdata;
                        we_q <= sel_req.we;
                        ch_q <= grant_idx;
                        take <= 1'b1;
                        cmd_q <= sdram_pkg::ACTIVATE;
                        state <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    step <= step + 1'b1;
                    if (step == STEP_BITS'(ACT_CMD)) begin
                        sdram_ba <= bank_q;
                        sdram_addr.access <= '{upper: '0, ap: 1'b1, col_row: LOW_BITS'(col_q)};
                        sdram_dqm <= 2'b00;
                        dq_oe <= we_q;
                        if (we_q) begin
                            cmd_q <= sdram_pkg::WRITE;
                        end else begin
                            cmd_q <= sdram_pkg::READ;
                        end
                    end
                    if (step == STEP_BITS'(ACT_READY)) begin
                        cmpl.valid <= 1'b1;
                        cmpl.we <= we_q;
                        cmpl.ch <= ch_q;
                        cmpl.rdata <= sdram_dq;  // cas latency data
                    end
                    if ((!we_q && step == STEP_BITS'(sdram_pkg::READ_PERIOD))
                        || (we_q && step == STEP_BITS'(sdram_pkg::WRITE_PERIOD))) begin
                        sdram_dqm <= 2'b11;
                        state <= IDLE;
                    end
                end
                REFRESH: begin
                    step <= step + 1'b1;
                    if (step == STEP_BITS'(sdram_pkg::READ_PERIOD)) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= POWERUP;
                end
            endcase
        end
    end

    // dq is driven for the single write cycle only
    assert property (@(posedge sdram_clk) disable iff (reset)
        dq_oe |-> (cmd_q == sdram_pkg::WRITE) ##1 !dq_oe);

endmodule

//--- sdram_ctrl_top.sv
`timescale 1ns/1ps

module sdram_ctrl_top #(
    parameter int num_ch = 2,
    parameter int init_pause = 26_667,
    parameter int refresh_interval = 2080
) (
    input  logic                            sdram_clk,
    input  logic                            reset,
    input  logic                            init,
    input  logic                            refresh_hint,
    input  sdram_pkg::host_req_t            host_req [num_ch],
    output sdram_pkg::host_rsp_t            host_rsp [num_ch],
    output logic                            sdram_cs,
    output logic                            sdram_ras,
    output logic                            sdram_cas,
    output logic                            sdram_we,
    output logic [sdram_pkg::BANK_BITS-1:0] sdram_ba,
    output sdram_pkg::sdram_addr_u          sdram_addr,
    output logic [1:0]                      sdram_dqm,
    inout  wire  [15:0]                     sdram_dq
);

    sdram_pkg::pending_req_t pend [num_ch];
    sdram_pkg::pending_req_t sel_req;
    sdram_pkg::ch_idx_t      grant_idx;
    sdram_pkg::completion_t  cmpl;
    logic                    refresh_due;
    logic                    refresh_done;
    logic                    cfg_done;

    for (genvar i = 0; i < num_ch; i++) begin : g_ch
        channel_port u_port (
            .sdram_clk (sdram_clk),
            .reset     (reset),
            .idx       (sdram_pkg::ch_idx_t'(i)),
            .req_in    (host_req[i]),
            .cmpl      (cmpl),
            .pend      (pend[i]),
            .rsp       (host_rsp[i])
        );
    end

    request_arbiter #(
        .num_ch (num_ch)
    ) u_arb (
        .pend      (pend),
        .sel_req   (sel_req),
        .grant_idx (grant_idx)
    );

    refresh_timer #(
        .refresh_interval (refresh_interval)
    ) u_refresh (
        .sdram_clk    (sdram_clk),
        .reset        (reset),
        .enable       (cfg_done),  // timer starts once the device is set up
        .refresh_hint (refresh_hint),
        .refresh_done (refresh_done),
        .refresh_due  (refresh_due)
    );

    sdram_sequencer #(
        .init_pause (init_pause)
    ) u_seq (
        .sdram_clk    (sdram_clk),
        .reset        (reset),
        .init         (init),
        .sel_req      (sel_req),
        .grant_idx    (grant_idx),
        .refresh_due  (refresh_due),
        .take         (),
        .refresh_done (refresh_done),
        .cfg_done     (cfg_done),
        .cmpl         (cmpl),
        .sdram_cs     (sdram_cs),
        .sdram_ras    (sdram_ras),
        .sdram_cas    (sdram_cas),
        .sdram_we     (sdram_we),
        .sdram_ba     (sdram_ba),
        .sdram_addr   (sdram_addr),
        .sdram_dqm    (sdram_dqm),
        .sdram_dq     (sdram_dq)
    );

endmodule

//--- tb_sdram_model.sv
`timescale 1ns/1ps

module tb_sdram_model #(
    parameter int init_pause = 40
) (
    input  logic                            sdram_clk,
    input  logic                            reset,
    input  logic                            sdram_cs,
    input  logic                            sdram_ras,
    input  logic                            sdram_cas,
    input  logic                            sdram_we,
    input  logic [sdram_pkg::BANK_BITS-1:0] sdram_ba,
    input  sdram_pkg::sdram_addr_u          sdram_addr,
    input  logic [1:0]                      sdram_dqm,
    inout  wire  [15:0]                     sdram_dq,
    output int                              refresh_count,
    output int                              order_errors,
    output int                              init_cmds,
    output logic                            mode_ok
);

    sdram_pkg::sdram_cmd_e                cmd;
    logic [15:0]                          mem [int];
    logic [sdram_pkg::ROW_BITS-1:0]       open_row [4];
    int                                   act_cycle [4];
    logic [3:0]                           row_open;
    int                                   cycle;
    logic [sdram_pkg::CAS_LATENCY-1:0]    rd_pipe;
    logic [15:0]                          rd_word;
    logic                                 dq_oe;

    assign cmd = sdram_cs ? sdram_pkg::NOOP
        : sdram_pkg::sdram_cmd_e'({sdram_ras, sdram_cas, sdram_we});
    assign sdram_dq = dq_oe ? rd_word : 'z;

    function automatic sdram_pkg::sdram_cmd_e init_cmd(input int n);
        case (n)
            0: return sdram_pkg::PRECHARGE;
            1: return sdram_pkg::MODE_REGISTER_SET;
            default: return sdram_pkg::AUTO_REFRESH;
        endcase
    endfunction

    task automatic protocol_error(input string msg);
        order_errors++;
        $display("protocol error at %0t: %s", $time, msg);
    endtask

    always @(posedge sdram_clk) begin
        logic [1:0] bank;
        logic       in_cfg;
        logic       rd_start;
        int         idx;
        bank = sdram_ba;
        rd_start = 1'b0;
        if (reset) begin
            cycle = 0;
            refresh_count = 0;
            order_errors = 0;
            init_cmds = 0;
            mode_ok = 1'b0;
            row_open = '0;
            rd_pipe = '0;
        end else begin
            cycle++;
            in_cfg = (init_cmds < 4);
            if (cmd != sdram_pkg::NOOP && cycle <= init_pause) begin
                protocol_error("command issued during the power-up pause");
            end
            if (cmd != sdram_pkg::NOOP && in_cfg) begin
                if (cmd != init_cmd(init_cmds)) begin
                    protocol_error("configuration command out of order");
                end
                init_cmds++;
            end
            case (cmd)
                sdram_pkg::PRECHARGE: begin
                    if (!in_cfg || !sdram_addr.access.ap) begin
                        protocol_error("precharge outside configuration or not all banks");
                    end
                end
                sdram_pkg::MODE_REGISTER_SET: begin
                    mode_ok = (sdram_addr.mode.cas_latency == 3'd2)
                        && (sdram_addr.mode.burst_len == 3'd0)
                        && sdram_addr.mode.write_burst  // single write
                        && !sdram_addr.mode.addr_type && (sdram_addr.mode.op_mode == 2'b00);
                end
                sdram_pkg::AUTO_REFRESH: begin
                    if (|row_open) begin
                        protocol_error("auto-refresh while a row is open");
                    end
                    refresh_count++;
                end
                sdram_pkg::ACTIVATE: begin
                    if (in_cfg || row_open[bank]) begin
                        protocol_error("activate before configuration or on an open bank");
                    end
                    row_open[bank] = 1'b1;
                    open_row[bank] = sdram_addr;
                    act_cycle[bank] = cycle;
                end
                sdram_pkg::READ, sdram_pkg::WRITE: begin
                    if (!row_open[bank] || (cycle - act_cycle[bank] < sdram_pkg::T_RCD)
                        || !sdram_addr.access.ap || sdram_dqm != 2'b00) begin
                        protocol_error("access without an open row, tRCD, auto-precharge or dqm");
                    end
                    idx = {bank, open_row[bank], sdram_addr.access.col_row[7:0]};
                    row_open[bank] = 1'b0;  // auto-precharge
                    if (cmd == sdram_pkg::WRITE) begin
                        mem[idx] = sdram_dq;
                    end else begin
                        rd_word = mem.exists(idx) ? mem[idx] : (16'(idx) ^ 16'(idx >> 16));
                        rd_start = 1'b1;
                    end
                end
                default: begin
                end
            endcase
            rd_pipe = {rd_pipe[sdram_pkg::CAS_LATENCY-2:0], rd_start};
        end
    end

    // half a cycle of margin on either side of the sampling edge
    always @(negedge sdram_clk) begin
        dq_oe <= !reset && rd_pipe[sdram_pkg::CAS_LATENCY-1];
    end

endmodule

//--- tb_sdram_ctrl.sv
`timescale 1ns/1ps

module tb_sdram_ctrl;

    localparam int NUM_CH = 2;
    localparam int INIT_PAUSE = 40;
    localparam int REFRESH_INTERVAL = 300;
    localparam int PASSES = 5;  // per refresh phase
    localparam int CFG_CYCLES = sdram_pkg::T_RP + sdram_pkg::T_MRD
        + 2 * sdram_pkg::READ_PERIOD + 2;

    typedef struct packed {
        logic [3:0]            ch;
        logic                  we;
        logic                  rnd;
        logic                  pair;  // launched together with the next line
        sdram_pkg::host_addr_t addr;
        logic [15:0]           wdata;
        logic [15:0]           expected;
    } test_op_t;

    logic                            sdram_clk;
    logic                            reset;
    logic                            init;
    logic                            refresh_hint;
    sdram_pkg::host_req_t            host_req [NUM_CH];
    sdram_pkg::host_rsp_t            host_rsp [NUM_CH];
    logic                            sdram_cs;
    logic                            sdram_ras;
    logic                            sdram_cas;
    logic                            sdram_we;
    logic [sdram_pkg::BANK_BITS-1:0] sdram_ba;
    sdram_pkg::sdram_addr_u          sdram_addr;
    logic [1:0]                      sdram_dqm;
    wire  [15:0]                     sdram_dq;
    int                              refresh_count;
    int                              order_errors;
    int                              init_cmds;
    logic                            mode_ok;

    test_op_t    ops [$];
    logic [15:0] rnd_q [$];  // random words written, oldest first
    logic [31:0] lcg_state;
    int          cycle = 0;
    int          cycle_limit = 0;
    int          data_errors = 0;
    int          count_errors = 0;
    int          other_errors = 0;

    sdram_ctrl_top #(
        .num_ch           (NUM_CH),
        .init_pause       (INIT_PAUSE),
        .refresh_interval (REFRESH_INTERVAL)
    ) DUT (
        .sdram_clk    (sdram_clk),
        .reset        (reset),
        .init         (init),
        .refresh_hint (refresh_hint),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .sdram_cs     (sdram_cs),
        .sdram_ras    (sdram_ras),
        .sdram_cas    (sdram_cas),
        .sdram_we     (sdram_we),
        .sdram_ba     (sdram_ba),
        .sdram_addr   (sdram_addr),
        .sdram_dqm    (sdram_dqm),
        .sdram_dq     (sdram_dq)
    );

    tb_sdram_model #(
        .init_pause (INIT_PAUSE)
    ) u_model (
        .sdram_clk     (sdram_clk),
        .reset         (reset),
        .sdram_cs      (sdram_cs),
        .sdram_ras     (sdram_ras),
        .sdram_cas     (sdram_cas),
        .sdram_we      (sdram_we),
        .sdram_ba      (sdram_ba),
        .sdram_addr    (sdram_addr),
        .sdram_dqm     (sdram_dqm),
        .sdram_dq      (sdram_dq),
        .refresh_count (refresh_count),
        .order_errors  (order_errors),
        .init_cmds     (init_cmds),
        .mode_ok       (mode_ok)
    );

    initial begin
        sdram_clk = 1'b0;
        forever #4 sdram_clk = ~sdram_clk;
    end

    always @(posedge sdram_clk) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] lcg_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic check_rsp(input int ch, input sdram_pkg::host_rsp_t rsp,
                             input logic [15:0] expected);
        if (rsp.rdata !== expected) begin
            data_errors++;
            $display("mismatch at %0t: channel %0d read %h, expected %h",
                     $time, ch, rsp.rdata, expected);
        end
    endtask

    // the model keeps words at {bank, row, column}
    task automatic compare_stored(input sdram_pkg::host_addr_t addr,
                                  input logic [15:0] expected);
        int idx;
        idx = int'({addr.bank, addr.row, addr.col});
        if (!u_model.mem.exists(idx) || u_model.mem[idx] !== expected) begin
            data_errors++;
            $display("mismatch at %0t: bank %0d row %h col %h does not hold %h",
                     $time, addr.bank, addr.row, addr.col, expected);
        end
    endtask

    task automatic check_count(input string what, input int got, input int lo, input int hi);
        if (got < lo || got > hi) begin
            count_errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    task automatic read_tests();
        int       fd;
        string    line;
        int       f [9];
        test_op_t op;
        fd = $fopen("sdram_ctrl_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the test file sdram_ctrl_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                            f[4], f[5], f[6], f[7], f[8]) == 9) begin
                    op.ch = 4'(f[0]);
                    op.we = f[1][0];
                    op.rnd = f[2][0];
                    op.pair = f[3][0];
                    op.addr.bank = 2'(f[4]);
                    op.addr.col = 8'(f[5]);
                    op.addr.row = 12'(f[6]);
                    op.wdata = 16'(f[7]);
                    op.expected = 16'(f[8]);
                    ops.push_back(op);
                end
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge with the channel idle
    task automatic launch(input test_op_t op, output logic [15:0] expected);
        int ch;
        ch = int'(op.ch);
        expected = op.expected;
        host_req[ch].we = op.we;
        host_req[ch].addr = op.addr;
        host_req[ch].wdata = op.wdata;
        if (op.rnd && op.we) begin
            host_req[ch].wdata = lcg_word();
            rnd_q.push_back(host_req[ch].wdata);
        end else if (op.rnd && rnd_q.size() == 0) begin
            other_errors++;
            $display("random read at %0t has no random write before it", $time);
        end else if (op.rnd) begin
            expected = rnd_q.pop_front();
        end
        host_req[ch].req = !host_req[ch].req;
    endtask

    task automatic wait_acks(input int ch_a, input int ch_b, output int cyc_a, output int cyc_b);
        cyc_a = -1;
        cyc_b = -1;
        while (cyc_a < 0 || cyc_b < 0) begin
            @(negedge sdram_clk);
            if (cyc_a < 0 && host_rsp[ch_a].ack == host_req[ch_a].req) begin
                cyc_a = cycle;
            end
            if (cyc_b < 0 && host_rsp[ch_b].ack == host_req[ch_b].req) begin
                cyc_b = cycle;
            end
        end
    endtask

    task automatic run_pass();
        int          i;
        int          cyc_a;
        int          cyc_b;
        logic [15:0] exp_a;
        logic [15:0] exp_b;
        test_op_t    a;
        test_op_t    b;
        i = 0;
        while (i < ops.size()) begin
            a = ops[i];
            launch(a, exp_a);
            if (a.pair && i + 1 < ops.size()) begin
                b = ops[i + 1];
                launch(b, exp_b);
                wait_acks(int'(a.ch), int'(b.ch), cyc_a, cyc_b);
                check_count("lower channel acked first",
                            int'((a.ch < b.ch) == (cyc_a < cyc_b)), 1, 1);
                if (b.we) begin
                    compare_stored(b.addr, host_req[b.ch].wdata);
                end else begin
                    check_rsp(int'(b.ch), host_rsp[b.ch], exp_b);
                end
                i += 2;
            end else begin
                wait_acks(int'(a.ch), int'(a.ch), cyc_a, cyc_b);
                i++;
            end
            if (a.we) begin
                compare_stored(a.addr, host_req[a.ch].wdata);
            end else begin
                check_rsp(int'(a.ch), host_rsp[a.ch], exp_a);
            end
        end
    endtask

    // a refresh may wait behind one write access
    task automatic check_refresh_rate(input string what, input int start_cyc,
                                      input int start_cnt, input int interval);
        int run_len;
        run_len = cycle - start_cyc;
        check_count(what, refresh_count - start_cnt,
                    run_len / (interval + sdram_pkg::WRITE_PERIOD + 2), run_len / interval + 1);
    endtask

    initial begin : main
        int ops_total;
        int phase_cyc;
        int phase_cnt;
        reset = 1'b1;
        init = 1'b0;
        refresh_hint = 1'b0;
        foreach (host_req[i]) host_req[i] = '0;
        lcg_state = 32'he7b81c1e;
        read_tests();
        ops_total = ops.size() * 2 * PASSES;
        cycle_limit = ops_total * (sdram_pkg::WRITE_PERIOD + 4) + INIT_PAUSE + CFG_CYCLES + 16;
        cycle_limit += (cycle_limit / (REFRESH_INTERVAL / 2) + 1) * (sdram_pkg::READ_PERIOD + 2);

        repeat (16) @(posedge sdram_clk);
        @(negedge sdram_clk);
        reset = 1'b0;
        init = 1'b1;
        while (init_cmds < 4) @(negedge sdram_clk);
        check_count("protocol errors during configuration", order_errors, 0, 0);
        check_count("mode register decode", int'(mode_ok), 1, 1);
        repeat (sdram_pkg::READ_PERIOD + 1) @(negedge sdram_clk);

        phase_cyc = cycle;
        phase_cnt = refresh_count;
        repeat (PASSES) run_pass();
        check_refresh_rate("refreshes without hint", phase_cyc, phase_cnt, REFRESH_INTERVAL);

        refresh_hint = 1'b1;
        phase_cyc = cycle;
        phase_cnt = refresh_count;
        repeat (PASSES) run_pass();
        check_refresh_rate("refreshes with hint", phase_cyc, phase_cnt, REFRESH_INTERVAL / 2);
        check_count("protocol errors", order_errors, 0, 0);

        $display("errors: data %0d, count %0d, other %0d", data_errors, count_errors,
                 other_errors);
        if (data_errors + count_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sdram_ctrl_tests.txt
# ch we rnd pair bank col row wdata expect, all hex, one operation per line
# rnd writes take LCG data, a rnd read expects the oldest unread LCG word
# pair launches this line and the next one in the same cycle
0 1 0 0 0 00 000 1234 0000
0 0 0 0 0 00 000 0000 1234
1 1 0 0 1 05 123 abcd 0000
1 0 0 0 1 05 123 0000 abcd
0 1 0 0 2 ff fff 5a5a 0000
1 0 0 0 2 ff fff 0000 5a5a
0 1 0 1 3 10 400 c0de 0000
1 1 0 0 3 11 400 beef 0000
1 0 0 1 3 10 400 0000 c0de
0 0 0 0 3 11 400 0000 beef
1 1 0 0 0 00 000 0f0f 0000
0 0 0 0 0 00 000 0000 0f0f
0 1 1 0 0 3c 0a5 0000 0000
1 1 1 0 1 c3 5a0 0000 0000
0 1 1 0 2 7e 81f 0000 0000
1 1 1 0 3 81 f3c 0000 0000
1 0 1 0 0 3c 0a5 0000 0000
0 0 1 0 1 c3 5a0 0000 0000
0 0 1 0 2 7e 81f 0000 0000
1 0 1 0 3 81 f3c 0000 0000

//--- sdram_ctrl_top.f
sdram_pkg.sv
channel_port.sv
request_arbiter.sv
refresh_timer.sv
sdram_sequencer.sv
sdram_ctrl_top.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_sdram_ctrl
FILELIST ?= sdram_ctrl_top.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
